//--- rtl/mmacc_pkg.sv
// MMACC command plane definitions

package mmacc_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int PID_W     = 4;
  localparam int PBS_CMD_W = 16;
  localparam int ICMD_W    = 16;

  // Info field takes what is left above parity and pid
  localparam int ICMD_INFO_W = ICMD_W - PID_W - 1;

  // ------------------------------------------------------------
  // Default sizes
  // ------------------------------------------------------------
  localparam int BATCH_PBS_NB    = 8;
  localparam int ENQ_DELAY       = 8;
  localparam int FEED_FIFO_DEPTH = 2;
  localparam int FLUSH_BUF_DEPTH = 2;

  // ------------------------------------------------------------
  // Internal command word
  // ------------------------------------------------------------
  // Stored raw in the FIFOs, decoded by the fork
  typedef union packed {
    logic [ICMD_W-1:0] raw;
    struct packed {
      logic [ICMD_INFO_W-1:0] info;
      logic                   br_loop_parity;
      logic [PID_W-1:0]       pid;
    } fields;
  } mmacc_icmd_u;

endpackage

//--- rtl/cmd_fifo.sv
// Register FIFO with valid/ready
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             s_rst_n,

  input  logic [WIDTH-1:0] in_data_i,
  input  logic             in_vld_i,
  output logic             in_rdy_o,

  output logic [WIDTH-1:0] out_data_o,
  output logic             out_vld_o,
  input  logic             out_rdy_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Wrap at DEPTH, which need not be a power of 2
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Space is judged on the current count only
  assign in_rdy_o   = (count < CNT_W'(DEPTH));
  assign out_vld_o  = (count != '0);
  assign push       = in_vld_i & in_rdy_o;
  assign pop        = out_vld_o & out_rdy_i;
  assign out_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/feed_cmd_path.sv
// Feed command path
`timescale 1ns/1ps

module feed_cmd_path #(
  parameter int ENQ_DELAY = 8
) (
  input  logic                           clk,
  input  logic                           s_rst_n,

  input  logic [mmacc_pkg::PBS_CMD_W-1:0] seq_pbs_cmd_i,
  input  logic                           seq_pbs_cmd_avail_i,
  output logic                           pbs_seq_cmd_enquiry_o,

  output logic [mmacc_pkg::PBS_CMD_W-1:0] feed_pcmd_o,
  output logic                           feed_vld_o,
  input  logic                           feed_rdy_i
);

  import mmacc_pkg::*;

  logic                 ffifo_in_rdy;
  logic                 feed_xfer;
  logic [ENQ_DELAY-1:0] enq_init;
  logic                 enq_d;

  // Sequencer strobe has no ready, the enquiry scheme keeps it in bounds
  cmd_fifo #(
    .WIDTH (PBS_CMD_W),
    .DEPTH (FEED_FIFO_DEPTH)
  ) feed_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (seq_pbs_cmd_i),
    .in_vld_i   (seq_pbs_cmd_avail_i),
    .in_rdy_o   (ffifo_in_rdy),
    .out_data_o (feed_pcmd_o),
    .out_vld_o  (feed_vld_o),
    .out_rdy_i  (feed_rdy_i)
  );

  // ------------------------------------------------------------
  // Enquiry
  // ------------------------------------------------------------
  // One-hot token walks out of the register after reset
  assign feed_xfer = feed_vld_o & feed_rdy_i;
  assign enq_d     = enq_init[ENQ_DELAY-1] | feed_xfer;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      enq_init              <= ENQ_DELAY'(1);
      pbs_seq_cmd_enquiry_o <= 1'b0;
    end else begin
      enq_init              <= enq_init << 1;
      pbs_seq_cmd_enquiry_o <= enq_d;
    end
  end

endmodule

//--- rtl/sxt_fork.sv
// Sample-extract and body-RAM request fork
`timescale 1ns/1ps

module sxt_fork #(
  parameter int DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        s_rst_n,

  input  mmacc_pkg::mmacc_icmd_u      acc_sfifo_icmd_i,
  input  logic                        acc_sfifo_avail_i,

  output mmacc_pkg::mmacc_icmd_u      sxt_icmd_o,
  output logic                        sxt_vld_o,
  input  logic                        sxt_rdy_i,

  output logic [mmacc_pkg::PID_W-1:0] boram_pid_o,
  output logic                        boram_parity_o,
  output logic                        boram_vld_o,
  input  logic                        boram_rdy_i,

  output logic                        sfifo_ovf_error_o
);

  import mmacc_pkg::*;

  logic           sfifo_in_rdy;
  logic           bfifo_in_rdy;
  logic           fork_push;
  logic           ovf_d;
  logic [PID_W:0] bfifo_in_data;
  logic [PID_W:0] bfifo_out_data;

  // Both or neither
  assign fork_push = acc_sfifo_avail_i & sfifo_in_rdy & bfifo_in_rdy;
  assign ovf_d     = acc_sfifo_avail_i & ~(sfifo_in_rdy & bfifo_in_rdy);

  // Body RAM only needs pid and loop parity
  assign bfifo_in_data  = {acc_sfifo_icmd_i.fields.br_loop_parity, acc_sfifo_icmd_i.fields.pid};
  assign boram_parity_o = bfifo_out_data[PID_W];
  assign boram_pid_o    = bfifo_out_data[PID_W-1:0];

  cmd_fifo #(
    .WIDTH (ICMD_W),
    .DEPTH (DEPTH)
  ) sxt_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (acc_sfifo_icmd_i.raw),
    .in_vld_i   (fork_push),
    .in_rdy_o   (sfifo_in_rdy),
    .out_data_o (sxt_icmd_o.raw),
    .out_vld_o  (sxt_vld_o),
    .out_rdy_i  (sxt_rdy_i)
  );

  cmd_fifo #(
    .WIDTH (PID_W + 1),
    .DEPTH (DEPTH)
  ) boram_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (bfifo_in_data),
    .in_vld_i   (fork_push),
    .in_rdy_o   (bfifo_in_rdy),
    .out_data_o (bfifo_out_data),
    .out_vld_o  (boram_vld_o),
    .out_rdy_i  (boram_rdy_i)
  );

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sfifo_ovf_error_o <= 1'b0;
    end else begin
      sfifo_ovf_error_o <= ovf_d;
    end
  end

endmodule

//--- rtl/bsk_rd_ptr_ctrl.sv
// Key read pointer increment control
`timescale 1ns/1ps

module bsk_rd_ptr_ctrl #(
  parameter int FLUSH_DEPTH = 2
) (
  input  logic clk,
  input  logic s_rst_n,

  input  logic br_loop_proc_done_i,
  input  logic br_loop_flush_done_i,

  output logic inc_bsk_rd_ptr_o,
  output logic flush_error_o
);

  localparam int CNT_W = $clog2(FLUSH_DEPTH + 1);

  logic [CNT_W-1:0] flush_cnt;
  logic             flush_full;
  logic             flush_vld;
  logic             flush_accept;
  logic             flush_release;
  logic             inc_d;
  logic             err_d;

  // ------------------------------------------------------------
  // Waiting flush pulses
  // ------------------------------------------------------------
  assign flush_full    = (flush_cnt == CNT_W'(FLUSH_DEPTH));
  assign flush_vld     = (flush_cnt != '0);
  assign flush_accept  = br_loop_flush_done_i & ~flush_full;
  // Processing-done has priority on the increment
  assign flush_release = flush_vld & ~br_loop_proc_done_i;

  assign inc_d = br_loop_proc_done_i | flush_release;
  assign err_d = br_loop_flush_done_i & flush_full;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      flush_cnt <= '0;
    end else begin
      case ({flush_accept, flush_release})
        2'b10:   flush_cnt <= flush_cnt + 1'b1;
        2'b01:   flush_cnt <= flush_cnt - 1'b1;
        default: flush_cnt <= flush_cnt;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      inc_bsk_rd_ptr_o <= 1'b0;
      flush_error_o    <= 1'b0;
    end else begin
      inc_bsk_rd_ptr_o <= inc_d;
      flush_error_o    <= err_d;
    end
  end

endmodule

//--- rtl/mmacc_cmd_ctrl.sv
// MMACC command plane top level
`timescale 1ns/1ps

module mmacc_cmd_ctrl #(
  parameter int BATCH_PBS_NB = mmacc_pkg::BATCH_PBS_NB,
  parameter int ENQ_DELAY    = mmacc_pkg::ENQ_DELAY,
  parameter int FLUSH_DEPTH  = mmacc_pkg::FLUSH_BUF_DEPTH
) (
  input  logic                            clk,
  input  logic                            s_rst_n,

  // Sequencer
  input  logic [mmacc_pkg::PBS_CMD_W-1:0] seq_pbs_cmd_i,
  input  logic                            seq_pbs_cmd_avail_i,
  output logic                            pbs_seq_cmd_enquiry_o,

  // Feed process
  output logic [mmacc_pkg::PBS_CMD_W-1:0] feed_pcmd_o,
  output logic                            feed_vld_o,
  input  logic                            feed_rdy_i,

  // Accumulate FIFO
  input  logic [mmacc_pkg::ICMD_W-1:0]    feed_icmd_i,
  input  logic                            feed_icmd_vld_i,
  output logic                            feed_icmd_rdy_o,
  output logic [mmacc_pkg::ICMD_W-1:0]    acc_icmd_o,
  output logic                            acc_vld_o,
  input  logic                            acc_rdy_i,

  // Finished commands
  input  mmacc_pkg::mmacc_icmd_u          acc_sfifo_icmd_i,
  input  logic                            acc_sfifo_avail_i,

  // Sample extract
  output mmacc_pkg::mmacc_icmd_u          sxt_icmd_o,
  output logic                            sxt_vld_o,
  input  logic                            sxt_rdy_i,

  // Body RAM request
  output logic [mmacc_pkg::PID_W-1:0]     boram_pid_o,
  output logic                            boram_parity_o,
  output logic                            boram_vld_o,
  input  logic                            boram_rdy_i,

  // Key pointer
  input  logic                            br_loop_proc_done_i,
  input  logic                            br_loop_flush_done_i,
  output logic                            inc_bsk_rd_ptr_o,

  // Errors
  output logic                            sfifo_ovf_error_o,
  output logic                            flush_error_o
);

  import mmacc_pkg::*;

  // ------------------------------------------------------------
  // Feed
  // ------------------------------------------------------------
  feed_cmd_path #(
    .ENQ_DELAY (ENQ_DELAY)
  ) feed_cmd_path_inst (
    .clk                   (clk),
    .s_rst_n               (s_rst_n),
    .seq_pbs_cmd_i         (seq_pbs_cmd_i),
    .seq_pbs_cmd_avail_i   (seq_pbs_cmd_avail_i),
    .pbs_seq_cmd_enquiry_o (pbs_seq_cmd_enquiry_o),
    .feed_pcmd_o           (feed_pcmd_o),
    .feed_vld_o            (feed_vld_o),
    .feed_rdy_i            (feed_rdy_i)
  );

  // ------------------------------------------------------------
  // Accumulate
  // ------------------------------------------------------------
  // Two extra slots cover feed running slightly ahead of acc
  cmd_fifo #(
    .WIDTH (ICMD_W),
    .DEPTH (BATCH_PBS_NB + 2)
  ) acc_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (feed_icmd_i),
    .in_vld_i   (feed_icmd_vld_i),
    .in_rdy_o   (feed_icmd_rdy_o),
    .out_data_o (acc_icmd_o),
    .out_vld_o  (acc_vld_o),
    .out_rdy_i  (acc_rdy_i)
  );

  // ------------------------------------------------------------
  // Sample extract and body RAM
  // ------------------------------------------------------------
  sxt_fork #(
    .DEPTH (BATCH_PBS_NB)
  ) sxt_fork_inst (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .acc_sfifo_icmd_i  (acc_sfifo_icmd_i),
    .acc_sfifo_avail_i (acc_sfifo_avail_i),
    .sxt_icmd_o        (sxt_icmd_o),
    .sxt_vld_o         (sxt_vld_o),
    .sxt_rdy_i         (sxt_rdy_i),
    .boram_pid_o       (boram_pid_o),
    .boram_parity_o    (boram_parity_o),
    .boram_vld_o       (boram_vld_o),
    .boram_rdy_i       (boram_rdy_i),
    .sfifo_ovf_error_o (sfifo_ovf_error_o)
  );

  // ------------------------------------------------------------
  // Key read pointer
  // ------------------------------------------------------------
  bsk_rd_ptr_ctrl #(
    .FLUSH_DEPTH (FLUSH_DEPTH)
  ) bsk_rd_ptr_ctrl_inst (
    .clk                  (clk),
    .s_rst_n              (s_rst_n),
    .br_loop_proc_done_i  (br_loop_proc_done_i),
    .br_loop_flush_done_i (br_loop_flush_done_i),
    .inc_bsk_rd_ptr_o     (inc_bsk_rd_ptr_o),
    .flush_error_o        (flush_error_o)
  );

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock generator
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

//--- verif/mmacc_cmd_ctrl_asserts.sv
// Handshake and enquiry assertions
`timescale 1ns/1ps

module mmacc_cmd_ctrl_asserts #(
  parameter int W = 16
) (
  input logic         clk,
  input logic         s_rst_n,
  input logic         strobe_i,
  input logic         full_i,
  input logic         vld_i,
  input logic         rdy_i,
  input logic [W-1:0] data_i,
  input logic         enq_i
);

  // Sequencer strobe has no ready, so room must already be there
  no_strobe_when_full: assert property (
    @(posedge clk) disable iff (!s_rst_n) strobe_i |-> !full_i
  ) else $error("Command strobe while the feed FIFO is full");

  vld_holds_data: assert property (
    @(posedge clk) disable iff (!s_rst_n) (vld_i && !rdy_i) |=> (vld_i && $stable(data_i))
  ) else $error("Output valid dropped or data changed while ready was low");

  rst_clears_enq: assert property (
    @(posedge clk) !s_rst_n |=> !enq_i
  ) else $error("Enquiry high after a reset cycle");

endmodule

bind feed_cmd_path mmacc_cmd_ctrl_asserts #(
  .W (mmacc_pkg::PBS_CMD_W)
) feed_asserts (
  .clk      (clk),
  .s_rst_n  (s_rst_n),
  .strobe_i (seq_pbs_cmd_avail_i),
  .full_i   (~ffifo_in_rdy),
  .vld_i    (feed_vld_o),
  .rdy_i    (feed_rdy_i),
  .data_i   (feed_pcmd_o),
  .enq_i    (pbs_seq_cmd_enquiry_o)
);

// Fork strobes may overflow on purpose, so only the output hold applies
bind sxt_fork mmacc_cmd_ctrl_asserts #(
  .W (mmacc_pkg::ICMD_W)
) sxt_asserts (
  .clk      (clk),
  .s_rst_n  (s_rst_n),
  .strobe_i (1'b0),
  .full_i   (1'b0),
  .vld_i    (sxt_vld_o),
  .rdy_i    (sxt_rdy_i),
  .data_i   (sxt_icmd_o),
  .enq_i    (1'b0)
);

//--- verif/mmacc_cmd_ctrl_tb.sv
// MMACC command plane testbench
`timescale 1ns/1ps

module mmacc_cmd_ctrl_tb;

  import mmacc_pkg::*;

  localparam int PERIOD         = 100;
  localparam int DRIVE_DLY      = 10;
  localparam int RST_CYCLES     = 2;
  localparam int TB_BATCH       = BATCH_PBS_NB;
  localparam int TB_ENQ_DELAY   = ENQ_DELAY;
  localparam int TB_FLUSH_DEPTH = FLUSH_BUF_DEPTH;
  localparam int ACC_DEPTH      = TB_BATCH + 2;
  localparam int N_SEQ          = 20;
  localparam int N_ACC          = 40;
  localparam int N_SXT          = 30;
  localparam int N_OVF          = TB_BATCH + 5;
  localparam int N_BSK          = 200;
  localparam int BURST_LEN      = 8;
  localparam int BURST_FLUSH    = 5;
  localparam int TEST_CYCLES    = RST_CYCLES + TB_ENQ_DELAY + 8 + N_SEQ * 16 + N_ACC * 10
                                  + (N_SXT + N_OVF) * 12 + N_BSK + BURST_LEN + 60;

  logic                 clk;
  logic                 s_rst_n;
  logic [PBS_CMD_W-1:0] seq_pbs_cmd_i;
  logic                 seq_pbs_cmd_avail_i;
  logic                 pbs_seq_cmd_enquiry_o;
  logic [PBS_CMD_W-1:0] feed_pcmd_o;
  logic                 feed_vld_o;
  logic                 feed_rdy_i;
  logic [ICMD_W-1:0]    feed_icmd_i;
  logic                 feed_icmd_vld_i;
  logic                 feed_icmd_rdy_o;
  logic [ICMD_W-1:0]    acc_icmd_o;
  logic                 acc_vld_o;
  logic                 acc_rdy_i;
  mmacc_icmd_u          acc_sfifo_icmd_i;
  logic                 acc_sfifo_avail_i;
  mmacc_icmd_u          sxt_icmd_o;
  logic                 sxt_vld_o;
  logic                 sxt_rdy_i;
  logic [PID_W-1:0]     boram_pid_o;
  logic                 boram_parity_o;
  logic                 boram_vld_o;
  logic                 boram_rdy_i;
  logic                 br_loop_proc_done_i;
  logic                 br_loop_flush_done_i;
  logic                 inc_bsk_rd_ptr_o;
  logic                 sfifo_ovf_error_o;
  logic                 flush_error_o;

  integer seed;
  logic   rst_done;
  logic   stall_acc;
  logic   stall_sxt;

  // Expected streams and event counters
  logic [PBS_CMD_W-1:0] exp_pcmd [$];
  mmacc_icmd_u          exp_acc [$];
  mmacc_icmd_u          exp_sxt [$];
  logic [PID_W:0]       exp_boram [$];
  int cyc           = 0;
  int first_enq_cyc = -1;
  int enq_cnt       = 0;
  int feed_xfer_cnt = 0;
  int acc_held      = 0;
  int sxt_held      = 0;
  int bor_held      = 0;
  int exp_ovf       = 0;
  int ovf_cnt       = 0;
  int inc_cnt       = 0;
  int ferr_cnt      = 0;

  tb_clk_gen #(
    .PERIOD (PERIOD)
  ) clk_gen_inst (
    .clk (clk)
  );

  mmacc_cmd_ctrl #(
    .BATCH_PBS_NB (TB_BATCH),
    .ENQ_DELAY    (TB_ENQ_DELAY),
    .FLUSH_DEPTH  (TB_FLUSH_DEPTH)
  ) mmacc_cmd_ctrl_inst (
    .clk                   (clk),
    .s_rst_n               (s_rst_n),
    .seq_pbs_cmd_i         (seq_pbs_cmd_i),
    .seq_pbs_cmd_avail_i   (seq_pbs_cmd_avail_i),
    .pbs_seq_cmd_enquiry_o (pbs_seq_cmd_enquiry_o),
    .feed_pcmd_o           (feed_pcmd_o),
    .feed_vld_o            (feed_vld_o),
    .feed_rdy_i            (feed_rdy_i),
    .feed_icmd_i           (feed_icmd_i),
    .feed_icmd_vld_i       (feed_icmd_vld_i),
    .feed_icmd_rdy_o       (feed_icmd_rdy_o),
    .acc_icmd_o            (acc_icmd_o),
    .acc_vld_o             (acc_vld_o),
    .acc_rdy_i             (acc_rdy_i),
    .acc_sfifo_icmd_i      (acc_sfifo_icmd_i),
    .acc_sfifo_avail_i     (acc_sfifo_avail_i),
    .sxt_icmd_o            (sxt_icmd_o),
    .sxt_vld_o             (sxt_vld_o),
    .sxt_rdy_i             (sxt_rdy_i),
    .boram_pid_o           (boram_pid_o),
    .boram_parity_o        (boram_parity_o),
    .boram_vld_o           (boram_vld_o),
    .boram_rdy_i           (boram_rdy_i),
    .br_loop_proc_done_i   (br_loop_proc_done_i),
    .br_loop_flush_done_i  (br_loop_flush_done_i),
    .inc_bsk_rd_ptr_o      (inc_bsk_rd_ptr_o),
    .sfifo_ovf_error_o     (sfifo_ovf_error_o),
    .flush_error_o         (flush_error_o)
  );

  // ------------------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------------------
  // Body RAM request is {parity, pid} of the command word
  function automatic logic [PID_W:0] expected_boram(input mmacc_icmd_u cmd);
    return {cmd.fields.br_loop_parity, cmd.fields.pid};
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_pcmd(input string name, input logic [PBS_CMD_W-1:0] exp,
                            input logic [PBS_CMD_W-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_icmd(input string name, input mmacc_icmd_u exp, input mmacc_icmd_u act);
    if (act.raw !== exp.raw) begin
      stop_on_error($sformatf("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                              $time, name, exp.raw, act.raw));
    end
  endtask

  task automatic check_boram(input logic [PID_W-1:0] exp_pid, input logic exp_par,
                             input logic [PID_W-1:0] act_pid, input logic act_par);
    if ((act_pid !== exp_pid) || (act_par !== exp_par)) begin
      stop_on_error($sformatf(
        "CHECK FAILED time=%0t signal=boram_pid_o/boram_parity_o expected=%h/%b actual=%h/%b",
        $time, exp_pid, exp_par, act_pid, act_par));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_on_error($sformatf("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
                              $time, name, exp, act));
    end
  endtask

  task automatic check_pending(input int size, input string name);
    if (size == 0) begin
      stop_on_error({"Transfer on ", name, " while no command was expected"});
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) step_cycle();
  endtask

  task automatic send_icmd(input logic [ICMD_W-1:0] data);
    feed_icmd_i     = data;
    feed_icmd_vld_i = 1'b1;
    do @(posedge clk); while (!feed_icmd_rdy_o);
    #DRIVE_DLY;
    feed_icmd_vld_i = 1'b0;
  endtask

  task automatic strobe_finished(input mmacc_icmd_u cmd);
    acc_sfifo_icmd_i  = cmd;
    acc_sfifo_avail_i = 1'b1;
    step_cycle();
    acc_sfifo_avail_i = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Random ready and compare processes
  // ------------------------------------------------------------
  always @(posedge clk) begin
    #DRIVE_DLY;
    feed_rdy_i  = rand_below(2);
    acc_rdy_i   = stall_acc ? 1'b0 : 1'(rand_below(2));
    sxt_rdy_i   = stall_sxt ? 1'b0 : 1'(rand_below(2));
    boram_rdy_i = rand_below(2);
  end

  always @(posedge clk) begin
    logic [PID_W:0] exp_b;
    logic           sxt_pop;
    logic           bor_pop;
    if (rst_done) begin
      if (pbs_seq_cmd_enquiry_o) begin
        enq_cnt++;
        if (first_enq_cyc < 0) first_enq_cyc = cyc;
      end
      cyc++;
      check_count("feed_icmd_rdy_o", (acc_held < ACC_DEPTH), feed_icmd_rdy_o);
    end
    // Pops first so a same-edge push never hides an empty queue
    if (feed_vld_o && feed_rdy_i) begin
      check_pending(exp_pcmd.size(), "feed_pcmd_o");
      check_pcmd("feed_pcmd_o", exp_pcmd.pop_front(), feed_pcmd_o);
      feed_xfer_cnt++;
    end
    if (seq_pbs_cmd_avail_i) exp_pcmd.push_back(seq_pbs_cmd_i);
    if (acc_vld_o && acc_rdy_i) begin
      check_pending(exp_acc.size(), "acc_icmd_o");
      check_icmd("acc_icmd_o", exp_acc.pop_front(), acc_icmd_o);
      acc_held--;
    end
    if (feed_icmd_vld_i && feed_icmd_rdy_o) begin
      exp_acc.push_back(feed_icmd_i);
      acc_held++;
    end
    sxt_pop = sxt_vld_o && sxt_rdy_i;
    bor_pop = boram_vld_o && boram_rdy_i;
    if (sxt_pop) begin
      check_pending(exp_sxt.size(), "sxt_icmd_o");
      check_icmd("sxt_icmd_o", exp_sxt.pop_front(), sxt_icmd_o);
    end
    if (bor_pop) begin
      check_pending(exp_boram.size(), "boram_pid_o");
      exp_b = exp_boram.pop_front();
      check_boram(exp_b[PID_W-1:0], exp_b[PID_W], boram_pid_o, boram_parity_o);
    end
    // Fork pushes both or neither, judged on space before this edge
    if (acc_sfifo_avail_i) begin
      if ((sxt_held < TB_BATCH) && (bor_held < TB_BATCH)) begin
        exp_sxt.push_back(acc_sfifo_icmd_i);
        exp_boram.push_back(expected_boram(acc_sfifo_icmd_i));
        sxt_held++;
        bor_held++;
      end else begin
        exp_ovf++;
      end
    end
    if (sxt_pop) sxt_held--;
    if (bor_pop) bor_held--;
    if (sfifo_ovf_error_o) ovf_cnt++;
    if (inc_bsk_rd_ptr_o) inc_cnt++;
    if (flush_error_o) ferr_cnt++;
  end

  initial begin
    #(2 * TEST_CYCLES * PERIOD);
    stop_on_error("Timeout: the run did not finish in the time allowed for the tests");
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    mmacc_icmd_u cmd;
    logic        p;
    logic        f;
    int          procs_sent;
    int          flush_sent;
    int          inc_base;
    int          ovf_base;
    int          ferr_base;
    seed                 = 32'hf015d469;
    rst_done             = 1'b0;
    stall_acc            = 1'b1;
    stall_sxt            = 1'b0;
    s_rst_n              = 1'b0;
    seq_pbs_cmd_i        = '0;
    seq_pbs_cmd_avail_i  = 1'b0;
    feed_rdy_i           = 1'b0;
    feed_icmd_i          = '0;
    feed_icmd_vld_i      = 1'b0;
    acc_rdy_i            = 1'b0;
    acc_sfifo_icmd_i     = '0;
    acc_sfifo_avail_i    = 1'b0;
    sxt_rdy_i            = 1'b0;
    boram_rdy_i          = 1'b0;
    br_loop_proc_done_i  = 1'b0;
    br_loop_flush_done_i = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    s_rst_n  = 1'b1;
    rst_done = 1'b1;

    // First enquiry after reset
    while ((enq_cnt == 0) && (cyc <= TB_ENQ_DELAY + 4)) step_cycle();
    check_count("first enquiry cycle", TB_ENQ_DELAY, first_enq_cyc);

    // Sequencer commands, one per enquiry
    for (int i = 0; i < N_SEQ; i++) begin
      while (enq_cnt <= i) step_cycle();
      seq_pbs_cmd_i       = $random(seed);
      seq_pbs_cmd_avail_i = 1'b1;
      step_cycle();
      seq_pbs_cmd_avail_i = 1'b0;
    end
    while (exp_pcmd.size() != 0) step_cycle();
    idle_cycles(3);
    check_count("pbs_seq_cmd_enquiry_o pulses", 1 + feed_xfer_cnt, enq_cnt);

    // Accumulate FIFO, stalled until full then random
    fork
      begin
        for (int i = 0; i < N_ACC; i++) begin
          idle_cycles(rand_below(2));
          send_icmd($random(seed));
        end
      end
      begin
        do @(posedge clk); while (feed_icmd_rdy_o);
        repeat (3) @(posedge clk);
        stall_acc = 1'b0;
      end
    join
    step_cycle();
    while (exp_acc.size() != 0) step_cycle();

    // Fork under random back-pressure
    for (int i = 0; i < N_SXT; i++) begin
      idle_cycles(rand_below(3));
      cmd = $random(seed);
      strobe_finished(cmd);
    end
    while ((exp_sxt.size() != 0) || (exp_boram.size() != 0)) step_cycle();
    step_cycle();
    check_count("sfifo_ovf_error_o pulses", exp_ovf, ovf_cnt);

    // Overflow with sample extract stalled
    ovf_base = ovf_cnt;
    @(posedge clk);
    stall_sxt = 1'b1;
    #DRIVE_DLY;
    for (int i = 0; i < N_OVF; i++) begin
      cmd = $random(seed);
      strobe_finished(cmd);
    end
    idle_cycles(2);
    check_count("dropped strobes", N_OVF - TB_BATCH, ovf_cnt - ovf_base);
    @(posedge clk);
    stall_sxt = 1'b0;
    #DRIVE_DLY;
    while ((exp_sxt.size() != 0) || (exp_boram.size() != 0)) step_cycle();
    check_count("sfifo_ovf_error_o pulses", exp_ovf, ovf_cnt);

    // Key pointer, random mix kept within the flush buffer
    procs_sent = 0;
    flush_sent = 0;
    inc_base   = inc_cnt;
    for (int i = 0; i < N_BSK; i++) begin
      p = rand_below(2);
      // Upper bound on waiting flushes from what was seen so far
      f = rand_below(2) &&
          ((flush_sent - (inc_cnt - inc_base - procs_sent)) < TB_FLUSH_DEPTH);
      br_loop_proc_done_i  = p;
      br_loop_flush_done_i = f;
      procs_sent += p;
      flush_sent += f;
      step_cycle();
    end
    br_loop_proc_done_i  = 1'b0;
    br_loop_flush_done_i = 1'b0;
    while ((inc_cnt - inc_base) < (procs_sent + flush_sent)) step_cycle();
    idle_cycles(4);
    check_count("inc_bsk_rd_ptr_o pulses", procs_sent + flush_sent, inc_cnt - inc_base);
    check_count("flush_error_o pulses", 0, ferr_cnt);

    // Flush burst while processing-done never stops
    inc_base  = inc_cnt;
    ferr_base = ferr_cnt;
    for (int i = 0; i < BURST_LEN; i++) begin
      br_loop_proc_done_i  = 1'b1;
      br_loop_flush_done_i = (i >= 1) && (i < 1 + BURST_FLUSH);
      step_cycle();
    end
    br_loop_proc_done_i  = 1'b0;
    br_loop_flush_done_i = 1'b0;
    while ((inc_cnt - inc_base) < (BURST_LEN + TB_FLUSH_DEPTH)) step_cycle();
    idle_cycles(4);
    check_count("flush_error_o pulses", BURST_FLUSH - TB_FLUSH_DEPTH, ferr_cnt - ferr_base);
    check_count("inc_bsk_rd_ptr_o pulses", BURST_LEN + TB_FLUSH_DEPTH, inc_cnt - inc_base);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- mmacc_cmd_ctrl.f
rtl/mmacc_pkg.sv
rtl/cmd_fifo.sv
rtl/feed_cmd_path.sv
rtl/sxt_fork.sv
rtl/bsk_rd_ptr_ctrl.sv
rtl/mmacc_cmd_ctrl.sv
verif/tb_clk_gen.sv
verif/mmacc_cmd_ctrl_asserts.sv
verif/mmacc_cmd_ctrl_tb.sv
